// File: compile.f
+incdir+include
hw/fifo_pkg.sv
hw/wb_pkg.sv
hw/fifo_mem.sv
hw/fifo_wr_ctl.sv
hw/fifo_rd_ctl.sv
hw/wb_fifo_port.sv
hw/cdc_fifo_wb_top.sv
test/cdc_fifo_wb_sva.sv
test/tb_cdc_fifo_wb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the CDC FIFO Wishbone testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

top=tb_cdc_fifo_wb
exe=sim_${top}

# Compile, assertions on, timing for the delay-driven testbench
verilator --binary --timing --assert --timescale 1ns/1ps \
  -f compile.f --top-module "${top}" -o "${exe}"
build_status=$?
if [ ${build_status} -ne 0 ]; then
  echo "Verilator build failed with status ${build_status}"
  exit 1
fi

# Run and keep stdout for the search below
sim_out=$(./obj_dir/"${exe}" 2>&1)
sim_status=$?
echo "${sim_out}"
if [ ${sim_status} -ne 0 ]; then
  echo "Simulation exited with status ${sim_status}"
  exit 1
fi

if grep -qx "Finished with no errors" <<< "${sim_out}"; then
  exit 0
else
  echo "Pass line not found in simulation output"
  exit 1
fi

// File: test/tb_cdc_fifo_wb.sv
`timescale 1ns/1ps

`include "fifo_consts.svh"

module tb_cdc_fifo_wb;

  import fifo_pkg::*;
  import wb_pkg::*;

  // About 60 bus accesses of up to 4 rd_clk and 40 pushes of 3 rd_clk
  // Roughly 400 cycles, so 2000 leaves ample margin
  localparam int TIMEOUT_CYCLES = 2000;

  logic       rd_clk;
  logic       wr_clk;
  logic       rst_n;
  wr_stream_t wr_in;
  logic       full;
  wb_req_t    wb_req;
  wb_rsp_t    wb_rsp;

  // Words accepted by the FIFO, oldest first
  fifo_word_t sb_q[$];
  int         seed;
  int         cycle_cnt;

  cdc_fifo_wb_top UUT (
    .wr_clk (wr_clk),
    .rd_clk (rd_clk),
    .rst_n  (rst_n),
    .wr_in  (wr_in),
    .full   (full),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp)
  );

  // --------------------------------------------------
  // Clocks and run limit
  // --------------------------------------------------
  // 4 ns read clock
  initial
  begin
    rd_clk = 1'b0;
    forever #2 rd_clk = ~rd_clk;
  end

  // 6 ns write clock
  initial
  begin
    wr_clk = 1'b0;
    forever #3 wr_clk = ~wr_clk;
  end

  initial cycle_cnt = 0;

  always @(posedge rd_clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES)
    begin
      $display("Timeout, run did not finish within %0d rd_clk cycles", TIMEOUT_CYCLES);
      report_failure();
    end
  end

  // --------------------------------------------------
  // Checks and expected values
  // --------------------------------------------------
  task automatic report_failure();
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    assert (act === exp)
    else
    begin
      $display("Error %s: expected 0x%0h actual 0x%0h", name, exp, act);
      report_failure();
    end
  endtask

  // STATUS layout: bit 0 empty, bit 1 underflow, level from bit 8
  function automatic logic [31:0] pack_status(input logic empty_bit, input logic uf_bit,
                                              input int level);
    logic [31:0] s;
    s = '0;
    s[0] = empty_bit;
    s[1] = uf_bit;
    s[8 +: 8] = 8'(level);
    return s;
  endfunction

  // --------------------------------------------------
  // Stream side
  // --------------------------------------------------
  // One word for one wr_clk, then an idle cycle
  task automatic push_word(input fifo_word_t word, output logic accepted);
    @(negedge wr_clk);
    wr_in.valid = 1'b1;
    wr_in.data  = word;
    // Full only moves on wr_clk rising edges
    accepted = !full;
    if (accepted)
      sb_q.push_back(word);
    @(negedge wr_clk);
    wr_in.valid = 1'b0;
  endtask

  task automatic push_random(output logic accepted);
    logic [31:0] rnd;
    rnd = $random(seed);
    push_word(rnd[`FIFO_DATA_W-1:0], accepted);
  endtask

  // --------------------------------------------------
  // Wishbone host
  // --------------------------------------------------
  // Cycles counts rd_clk from the sampling edge to the ack
  task automatic wb_access(input logic we, input logic [`WB_ADDR_W-1:0] addr,
                           input logic [31:0] wdata, output logic [31:0] rdata,
                           output int cycles);
    @(negedge rd_clk);
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.adr = addr;
    wb_req.dat = wdata;
    cycles = 0;
    do
    begin
      @(negedge rd_clk);
      cycles++;
    end
    while (!wb_rsp.ack);
    rdata = wb_rsp.dat;
    // Held through the edge that takes the ack
    @(negedge rd_clk);
    wb_req.cyc = 1'b0;
    wb_req.stb = 1'b0;
    wb_req.we  = 1'b0;
  endtask

  task automatic wb_read(input logic [`WB_ADDR_W-1:0] addr, output logic [31:0] rdata,
                         output int cycles);
    wb_access(1'b0, addr, 32'h0, rdata, cycles);
  endtask

  task automatic wb_write(input logic [`WB_ADDR_W-1:0] addr, input logic [31:0] wdata);
    logic [31:0] unused_dat;
    int          unused_cyc;
    wb_access(1'b1, addr, wdata, unused_dat, unused_cyc);
  endtask

  // Poll STATUS until the read side sees n words
  task automatic wait_level(input int n);
    logic [31:0] rdata;
    int          cycles;
    do
      wb_read(`WB_REG_STATUS, rdata, cycles);
    while (rdata[15:8] != 8'(n));
  endtask

  // DATA read compared with the scoreboard head
  task automatic pop_and_check(input string name, output int cycles);
    logic [31:0] rdata;
    fifo_word_t  exp;
    if (sb_q.size() == 0)
    begin
      $display("Error %s: DATA read attempted with no word left in the scoreboard", name);
      report_failure();
    end
    else
    begin
      exp = sb_q.pop_front();
      wb_read(`WB_REG_DATA, rdata, cycles);
      check_value(name, 32'(exp), rdata);
    end
  endtask

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial
  begin
    logic [31:0] rdata;
    int          cycles;
    int          accepted_cnt;
    int          offers;
    logic        refused;
    logic        acc;

    wr_in  = '0;
    wb_req = '0;
    rst_n  = 1'b0;
    seed   = 92013;
    repeat (2) @(negedge rd_clk);
    rst_n = 1'b1;

    // Reset state
    wb_read(`WB_REG_STATUS, rdata, cycles);
    check_value("reset_status", pack_status(1'b1, 1'b0, 0), rdata);
    check_value("reset_full", 32'd0, 32'(full));

    // Ordered transfer of 10 words
    for (int i = 0; i < 10; i++)
    begin
      push_random(acc);
      check_value("ordered_accept", 32'd1, 32'(acc));
    end
    wait_level(10);
    repeat (10) pop_and_check("ordered_data", cycles);
    wb_read(`WB_REG_STATUS, rdata, cycles);
    check_value("ordered_status", pack_status(1'b1, 1'b0, 0), rdata);

    // Fill until refused, the refused word never enters the scoreboard
    accepted_cnt = 0;
    offers       = 0;
    refused      = 1'b0;
    while (!refused && offers < `FIFO_DEPTH + 4)
    begin
      push_random(acc);
      offers++;
      if (acc)
        accepted_cnt++;
      else
        refused = 1'b1;
    end
    check_value("full_count", `FIFO_DEPTH, accepted_cnt);
    check_value("full_flag", 32'd1, 32'(full));
    wait_level(`FIFO_DEPTH);
    repeat (`FIFO_DEPTH) pop_and_check("full_drain", cycles);
    wb_read(`WB_REG_STATUS, rdata, cycles);
    check_value("full_status", pack_status(1'b1, 1'b0, 0), rdata);

    // Level after 5 pushes
    repeat (5)
    begin
      push_random(acc);
      check_value("level_accept", 32'd1, 32'(acc));
    end
    repeat (10) @(posedge rd_clk);
    wb_read(`WB_REG_STATUS, rdata, cycles);
    check_value("level_status", pack_status(1'b0, 1'b0, 5), rdata);
    repeat (5) pop_and_check("level_drain", cycles);

    // Underflow set by an empty DATA read, cleared by a STATUS write
    wb_read(`WB_REG_DATA, rdata, cycles);
    check_value("underflow_data", 32'd0, rdata);
    wb_read(`WB_REG_STATUS, rdata, cycles);
    check_value("underflow_set", pack_status(1'b1, 1'b1, 0), rdata);
    wb_write(`WB_REG_STATUS, 32'h0);
    wb_read(`WB_REG_STATUS, rdata, cycles);
    check_value("underflow_clear", pack_status(1'b1, 1'b0, 0), rdata);

    // Ack latency, STATUS one cycle, DATA with a word two cycles
    wb_read(`WB_REG_STATUS, rdata, cycles);
    check_value("ack_status_cycles", 32'd1, cycles);
    push_random(acc);
    wait_level(1);
    pop_and_check("ack_data_value", cycles);
    check_value("ack_data_cycles", 32'd2, cycles);

    $display("Finished with no errors");
    $finish;
  end

endmodule

// File: test/cdc_fifo_wb_sva.sv
`timescale 1ns/1ps

module cdc_fifo_wb_sva (
  input  logic                 rd_clk,
  input  logic                 wr_clk,
  input  logic                 rst_n,
  input  fifo_pkg::fifo_addr_t wr_addr,
  input  logic                 full,
  input  logic                 empty,
  input  logic                 pop,
  input  wb_pkg::wb_req_t      wb_req,
  input  wb_pkg::wb_rsp_t      wb_rsp
);

  // --------------------------------------------------
  // Wishbone handshake, rd_clk domain
  // --------------------------------------------------
  // Ack only answers a strobe already sampled on the previous edge
  ack_needs_stb: assert property (
    @(posedge rd_clk) disable iff (!rst_n)
    wb_rsp.ack |-> (wb_req.cyc && wb_req.stb && $past(wb_req.cyc && wb_req.stb)))
  else $error("ack high without a held cyc and stb");

  // Single cycle ack, FSM leaves PORT_ACK right away
  ack_one_cycle: assert property (
    @(posedge rd_clk) disable iff (!rst_n)
    wb_rsp.ack |=> !wb_rsp.ack)
  else $error("ack held for more than one cycle");

  // Quiet outputs on the first two edges out of reset
  quiet_after_reset: assert property (
    @(posedge rd_clk)
    $rose(rst_n) |-> (!full && !wb_rsp.ack) ##1 (!full && !wb_rsp.ack))
  else $error("full or ack high right after reset");

  // Port gates pop with empty
  no_pop_when_empty: assert property (
    @(posedge rd_clk) disable iff (!rst_n)
    pop |-> !empty)
  else $error("pop issued while empty");

  // --------------------------------------------------
  // Stream side, wr_clk domain
  // --------------------------------------------------
  // Write pointer holds while full, offered word is dropped
  no_write_when_full: assert property (
    @(posedge wr_clk) disable iff (!rst_n)
    full |=> $stable(wr_addr))
  else $error("word accepted while full");

endmodule

// Internal nets of the top level reach the checker by name
bind cdc_fifo_wb_top cdc_fifo_wb_sva u_sva (
  .rd_clk  (rd_clk),
  .wr_clk  (wr_clk),
  .rst_n   (rst_n),
  .wr_addr (wr_addr),
  .full    (full),
  .empty   (empty),
  .pop     (pop),
  .wb_req  (wb_req),
  .wb_rsp  (wb_rsp)
);

// File: hw/cdc_fifo_wb_top.sv
`timescale 1ns/1ps

module cdc_fifo_wb_top (
  input  logic                 wr_clk,
  input  logic                 rd_clk,
  input  logic                 rst_n,
  input  fifo_pkg::wr_stream_t wr_in,
  output logic                 full,
  input  wb_pkg::wb_req_t      wb_req,
  output wb_pkg::wb_rsp_t      wb_rsp
);

  import fifo_pkg::*;

  // --------------------------------------------------
  // Write domain nets
  // --------------------------------------------------
  logic        wr_en;
  fifo_addr_t  wr_addr;
  fifo_ptr_t   wr_gray;

  // --------------------------------------------------
  // Read domain nets
  // --------------------------------------------------
  logic        rd_en;
  fifo_addr_t  rd_addr;
  fifo_ptr_t   rd_gray;
  logic        empty;
  fifo_level_t level;
  fifo_word_t  rd_data;
  logic        pop;

  // Storage
  fifo_mem u_mem (
    .wr_clk  (wr_clk),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_in.data),
    .rd_clk  (rd_clk),
    .rst_n   (rst_n),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  // Producer side pointers and full
  fifo_wr_ctl u_wr_ctl (
    .wr_clk  (wr_clk),
    .rst_n   (rst_n),
    .wr_in   (wr_in),
    .rd_gray (rd_gray),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_gray (wr_gray),
    .full    (full)
  );

  // Consumer side pointers, empty and level
  fifo_rd_ctl u_rd_ctl (
    .rd_clk  (rd_clk),
    .rst_n   (rst_n),
    .pop     (pop),
    .wr_gray (wr_gray),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_gray (rd_gray),
    .empty   (empty),
    .level   (level)
  );

  // Host register port
  wb_fifo_port u_port (
    .rd_clk  (rd_clk),
    .rst_n   (rst_n),
    .wb_req  (wb_req),
    .wb_rsp  (wb_rsp),
    .empty   (empty),
    .level   (level),
    .rd_data (rd_data),
    .pop     (pop)
  );

endmodule

// File: hw/wb_fifo_port.sv
`timescale 1ns/1ps

`include "fifo_consts.svh"

module wb_fifo_port (
  input  logic                  rd_clk,
  input  logic                  rst_n,
  input  wb_pkg::wb_req_t       wb_req,
  output wb_pkg::wb_rsp_t       wb_rsp,
  input  logic                  empty,
  input  fifo_pkg::fifo_level_t level,
  input  fifo_pkg::fifo_word_t  rd_data,
  output logic                  pop
);

  import wb_pkg::*;

  wb_port_state_e state;
  wb_port_state_e state_nxt;
  // Decoded register for the current request
  wb_reg_e        reg_sel;
  // Request on the bus
  logic           req;
  // DATA read that finds no word
  logic           rd_under;
  // Set when the access went through FETCH
  logic           popped;
  // Sticky, cleared by a STATUS write
  logic           underflow;
  logic [`WB_DATA_W-1:0] status_word;

  // --------------------------------------------------
  // Decode
  // --------------------------------------------------
  assign req = wb_req.cyc && wb_req.stb;

  always_comb
  begin
    case (wb_req.adr)
      `WB_REG_DATA:   reg_sel = REG_DATA;
      `WB_REG_STATUS: reg_sel = REG_STATUS;
      default:        reg_sel = REG_NONE;
    endcase
  end

  assign rd_under = req && !wb_req.we && (reg_sel == REG_DATA) && empty;

  // --------------------------------------------------
  // FSM
  // --------------------------------------------------
  always_comb
  begin
    state_nxt = state;
    case (state)
      PORT_IDLE:
      begin
        if (req)
        begin
          // Only a DATA read with words waiting needs the memory
          if (!wb_req.we && (reg_sel == REG_DATA) && !empty)
            state_nxt = PORT_FETCH;
          else
            state_nxt = PORT_ACK;
        end
      end
      // Word registered in the memory this cycle
      PORT_FETCH: state_nxt = PORT_ACK;
      PORT_ACK:   state_nxt = PORT_IDLE;
      default:    state_nxt = PORT_IDLE;
    endcase
  end

  always_ff @(posedge rd_clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= PORT_IDLE;
      popped    <= 1'b0;
      underflow <= 1'b0;
    end
    else
    begin
      state <= state_nxt;
      if (state == PORT_IDLE && req)
      begin
        popped <= (state_nxt == PORT_FETCH);
        // Set wins, a read and a write are never sampled together
        if (rd_under)
          underflow <= 1'b1;
        else if (wb_req.we && (reg_sel == REG_STATUS))
          underflow <= 1'b0;
      end
    end
  end

  // Single pop per DATA read, one cycle in FETCH
  assign pop = (state == PORT_FETCH);

  // --------------------------------------------------
  // Response
  // --------------------------------------------------
  // Bit 0 empty, bit 1 underflow, level from bit 8
  always_comb
  begin
    status_word = '0;
    status_word[0] = empty;
    status_word[1] = underflow;
    status_word[8 +: $bits(level)] = level;
  end

  always_comb
  begin
    wb_rsp.ack = (state == PORT_ACK) && req;
    wb_rsp.dat = '0;
    if (state == PORT_ACK && !wb_req.we)
    begin
      case (reg_sel)
        // Zero on underflow, memory word after a pop
        REG_DATA:
        begin
          if (popped)
            wb_rsp.dat[`FIFO_DATA_W-1:0] = rd_data;
        end
        REG_STATUS: wb_rsp.dat = status_word;
        default:    wb_rsp.dat = '0;
      endcase
    end
  end

endmodule

// File: hw/fifo_rd_ctl.sv
`timescale 1ns/1ps

`include "fifo_consts.svh"

module fifo_rd_ctl (
  input  logic                  rd_clk,
  input  logic                  rst_n,
  input  logic                  pop,
  input  fifo_pkg::fifo_ptr_t   wr_gray,
  output logic                  rd_en,
  output fifo_pkg::fifo_addr_t  rd_addr,
  output fifo_pkg::fifo_ptr_t   rd_gray,
  output logic                  empty,
  output fifo_pkg::fifo_level_t level
);

  import fifo_pkg::*;

  // Binary read pointer with wrap bit
  fifo_ptr_t rd_bin;
  // Write Gray pointer, two flop synchronizer
  fifo_ptr_t wr_gray_s1;
  fifo_ptr_t wr_gray_s2;
  // Synchronized write pointer back in binary
  fifo_ptr_t wr_bin_s;

  // --------------------------------------------------
  // Pop and advance
  // --------------------------------------------------
  // Port never pops while empty
  assign rd_en = pop;

  always_ff @(posedge rd_clk or negedge rst_n)
  begin
    if (!rst_n)
      rd_bin <= '0;
    else if (pop)
      rd_bin <= rd_bin + 1'b1;
  end

  assign rd_addr = rd_bin[`FIFO_ADDR_W-1:0];

  // Binary to Gray, goes to the write side
  assign rd_gray = (rd_bin >> 1) ^ rd_bin;

  // --------------------------------------------------
  // Write pointer into rd_clk
  // --------------------------------------------------
  always_ff @(posedge rd_clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_gray_s1 <= '0;
      wr_gray_s2 <= '0;
    end
    else
    begin
      wr_gray_s1 <= wr_gray;
      wr_gray_s2 <= wr_gray_s1;
    end
  end

  // Same lap and same slot
  assign empty = (rd_gray == wr_gray_s2);

  // Gray to binary
  // Each bit is the XOR of all Gray bits above and itself
  always_comb
  begin
    wr_bin_s[`FIFO_ADDR_W] = wr_gray_s2[`FIFO_ADDR_W];
    for (int i = `FIFO_ADDR_W - 1; i >= 0; i--)
      wr_bin_s[i] = wr_bin_s[i+1] ^ wr_gray_s2[i];
  end

  // Fill level as seen from the read side
  // Wrap bit makes the subtraction come out right
  assign level = wr_bin_s - rd_bin;

endmodule

// File: hw/fifo_wr_ctl.sv
`timescale 1ns/1ps

`include "fifo_consts.svh"

module fifo_wr_ctl (
  input  logic                 wr_clk,
  input  logic                 rst_n,
  input  fifo_pkg::wr_stream_t wr_in,
  input  fifo_pkg::fifo_ptr_t  rd_gray,
  output logic                 wr_en,
  output fifo_pkg::fifo_addr_t wr_addr,
  output fifo_pkg::fifo_ptr_t  wr_gray,
  output logic                 full
);

  import fifo_pkg::*;

  // Binary write pointer with wrap bit
  fifo_ptr_t wr_bin;
  // Read Gray pointer, two flop synchronizer
  fifo_ptr_t rd_gray_s1;
  fifo_ptr_t rd_gray_s2;

  // --------------------------------------------------
  // Accept and advance
  // --------------------------------------------------
  // Only place where a write is refused
  assign wr_en = wr_in.valid && !full;

  always_ff @(posedge wr_clk or negedge rst_n)
  begin
    if (!rst_n)
      wr_bin <= '0;
    else if (wr_en)
      wr_bin <= wr_bin + 1'b1;
  end

  // Low bits index the memory
  assign wr_addr = wr_bin[`FIFO_ADDR_W-1:0];

  // Binary to Gray
  assign wr_gray = (wr_bin >> 1) ^ wr_bin;

  // --------------------------------------------------
  // Read pointer into wr_clk
  // --------------------------------------------------
  always_ff @(posedge wr_clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rd_gray_s1 <= '0;
      rd_gray_s2 <= '0;
    end
    else
    begin
      rd_gray_s1 <= rd_gray;
      rd_gray_s2 <= rd_gray_s1;
    end
  end

  // Full when writer is one lap ahead
  // In Gray this flips the two top bits
  assign full = (wr_gray == {~rd_gray_s2[`FIFO_ADDR_W -: 2],
                             rd_gray_s2[`FIFO_ADDR_W-2:0]});

endmodule

// File: hw/fifo_mem.sv
`timescale 1ns/1ps

`include "fifo_consts.svh"

module fifo_mem (
  input  logic                 wr_clk,
  input  logic                 wr_en,
  input  fifo_pkg::fifo_addr_t wr_addr,
  input  fifo_pkg::fifo_word_t wr_data,
  input  logic                 rd_clk,
  input  logic                 rst_n,
  input  logic                 rd_en,
  input  fifo_pkg::fifo_addr_t rd_addr,
  output fifo_pkg::fifo_word_t rd_data
);

  import fifo_pkg::*;

  // Storage, written from wr_clk and read from rd_clk
  fifo_word_t mem [`FIFO_DEPTH];

  // Write port
  // Enable already gated by full in the write control
  always_ff @(posedge wr_clk)
  begin
    if (wr_en)
      mem[wr_addr] <= wr_data;
  end

  // Registered read port
  // Holds the last word when no pop
  always_ff @(posedge rd_clk or negedge rst_n)
  begin
    if (!rst_n)
      rd_data <= '0;
    else if (rd_en)
      rd_data <= mem[rd_addr];
  end

endmodule

// File: hw/wb_pkg.sv
package wb_pkg;

  `include "fifo_consts.svh"

  // --------------------------------------------------
  // Bus signals
  // --------------------------------------------------
  // Host to slave, held until ack
  typedef struct packed {
    logic                  cyc;
    logic                  stb;
    logic                  we;
    logic [`WB_ADDR_W-1:0] adr;
    logic [`WB_DATA_W-1:0] dat;
  } wb_req_t;

  // Slave to host
  typedef struct packed {
    logic                  ack;
    logic [`WB_DATA_W-1:0] dat;
  } wb_rsp_t;

  // --------------------------------------------------
  // Port decode and FSM
  // --------------------------------------------------
  // Register selected by adr
  typedef enum logic [1:0] {
    REG_DATA,
    REG_STATUS,
    REG_NONE
  } wb_reg_e;

  // Slave FSM states
  // FETCH only on a DATA read with words waiting
  typedef enum logic [1:0] {
    PORT_IDLE,
    PORT_FETCH,
    PORT_ACK
  } wb_port_state_e;

endpackage

// File: hw/fifo_pkg.sv
package fifo_pkg;

  `include "fifo_consts.svh"

  // One stored word
  typedef logic [`FIFO_DATA_W-1:0] fifo_word_t;

  // Pointer with wrap bit
  // Same width whether binary or Gray
  typedef logic [`FIFO_ADDR_W:0] fifo_ptr_t;

  // Memory index, pointer without the wrap bit
  typedef logic [`FIFO_ADDR_W-1:0] fifo_addr_t;

  // Fill count, 0 up to FIFO_DEPTH inclusive
  typedef logic [`FIFO_ADDR_W:0] fifo_level_t;

  // Producer side stream
  // Word taken when valid is high and full is low
  typedef struct packed {
    logic       valid;
    fifo_word_t data;
  } wr_stream_t;

endpackage

// File: include/fifo_consts.svh
`ifndef FIFO_CONSTS_SVH
`define FIFO_CONSTS_SVH

// --------------------------------------------------
// FIFO geometry
// --------------------------------------------------
// Word width on the stream side
`define FIFO_DATA_W   16
// Address bits, pointers carry one extra wrap bit
`define FIFO_ADDR_W   4
// Entries, two to the power of the address width
`define FIFO_DEPTH    16

// --------------------------------------------------
// Wishbone register map
// --------------------------------------------------
`define WB_ADDR_W     4
`define WB_DATA_W     32
// Pop port
`define WB_REG_DATA   4'h0
// Empty, underflow and level
`define WB_REG_STATUS 4'h4

`endif
